// ==== sources.f ====
sd_init_pkg.sv
sd_crc7.sv
sd_clk_div.sv
sd_cmd_line.sv
sd_init_fsm.sv
sd_init_top.sv
tb_sd_init.sv

// ==== Bender.yml ====
package:
  name: sd_init

sources:
  - files:
      - sd_init_pkg.sv
      - sd_crc7.sv
      - sd_clk_div.sv
      - sd_cmd_line.sv
      - sd_init_fsm.sv
      - sd_init_top.sv
  - target: simulation
    files:
      - tb_sd_init.sv

// ==== tb_sd_init.sv ====
// Testbench for sd_init_top with a behavioral SD card on the CMD line, run by simulating tb_sd_init
`default_nettype none
`timescale 1ns/10ps

module tb_sd_init
    import sd_init_pkg::*;
();

    localparam int CLK_PERIOD_NS = 10;
    localparam int CLK_DIV = 2;
    localparam int RESET_CYCLES = 5;
    localparam int N_SCEN = 3;
    localparam int MAX_BUSY = 6;
    // CMD0, CMD8, CMD2, CMD3 plus the CMD55/ACMD41 pairs
    localparam int MAX_FRAMES = 4 + 2 * (MAX_BUSY + 1);
    localparam int SCLK_PERIOD_NS = 2 * (CLK_DIV + 1) * CLK_PERIOD_NS;
    localparam int WATCHDOG_NS = N_SCEN * MAX_FRAMES * 200 * SCLK_PERIOD_NS;
    localparam int SCEN_V2_HC = 0;
    localparam int SCEN_V1 = 1;
    localparam int SCEN_BAD_CRC = 2;
    localparam logic [31:0] CARD_STATUS = 32'h0000_0120;

    logic                   i_clk = 1'b0;
    logic                   i_nrst;
    logic [SD_CLKDIV_W-1:0] i_clk_div;
    logic             [3:0] i_vhs;
    logic             [7:0] i_check_pattern;
    logic                   i_cmd;
    logic                   o_sclk;
    logic                   o_cmd;
    logic                   o_cmd_dir;
    sd_card_info_t          o_card_info;
    logic                   o_init_done;

    sd_card_info_t exp_info;
    logic          info_checked;
    int            scen;

    sd_init_top u_dut (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_clk_div       (i_clk_div),
        .i_vhs           (i_vhs),
        .i_check_pattern (i_check_pattern),
        .i_cmd           (i_cmd),
        .o_sclk          (o_sclk),
        .o_cmd           (o_cmd),
        .o_cmd_dir       (o_cmd_dir),
        .o_card_info     (o_card_info),
        .o_init_done     (o_init_done)
    );

    always #(CLK_PERIOD_NS / 2) i_clk = ~i_clk;

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // CRC7 with generator x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] compute_crc7(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    // R1, R6 and R7 share one layout
    // A set corrupt flag flips the CRC LSB
    function automatic logic [135:0] build_short_resp(input logic [5:0] idx,
                                                      input logic [31:0] data,
                                                      input logic corrupt);
        logic [6:0] crc;
        crc = compute_crc7({2'b00, idx, data});
        if (corrupt) begin
            crc = crc ^ 7'h01;
        end
        return {88'h0, 2'b00, idx, data, crc, 1'b1};
    endfunction

    function automatic logic [135:0] build_ocr_resp(input logic ready, input logic ccs);
        return {88'h0, 2'b00, 6'h3F, ready, ccs, 6'h0, 24'hFF8000, 7'h7F, 1'b1};
    endfunction

    function automatic logic [135:0] build_cid_resp();
        logic [126:0] cid;
        cid = 127'({$urandom, $urandom, $urandom, $urandom});
        return {2'b00, 6'h3F, cid, 1'b1};
    endfunction

    function automatic sd_card_info_t expected_info(input int kind, input logic [15:0] rca);
        sd_card_info_t info;
        case (kind)
            SCEN_V2_HC: info = '{state: SDSTATE_STBY, sdtype: SDCARD_VER2X_HC, rca: rca};
            SCEN_V1: info = '{state: SDSTATE_STBY, sdtype: SDCARD_VER1X, rca: rca};
            // RCA never loads when the R6 fails its CRC
            default: info = '{state: SDSTATE_INA, sdtype: SDCARD_UNUSABLE, rca: 16'h0};
        endcase
        return info;
    endfunction

    // Card samples on the rising SD clock and counts idle rises before the start bit
    task automatic receive_frame(input logic check_idle, output logic [47:0] frame,
                                 output int idle_rises);
        logic started;
        started = 1'b0;
        idle_rises = 0;
        frame = '0;
        while (!started) begin
            @(posedge o_sclk);
            @(negedge i_clk);
            if (!o_cmd_dir && !o_cmd) begin
                started = 1'b1;
            end else begin
                if (check_idle) begin
                    check_value(o_cmd_dir, 1'b0, "cmd_dir high before the first command");
                end
                idle_rises++;
            end
        end
        for (int i = SD_CMD_BITS - 2; i >= 0; i--) begin
            @(posedge o_sclk);
            @(negedge i_clk);
            check_value(o_cmd_dir, 1'b0, "cmd_dir while the frame is driven");
            frame[i] = o_cmd;
        end
    endtask

    task automatic check_frame(input logic [47:0] frame, input logic [5:0] idx,
                               input logic [31:0] arg);
        check_value(frame[47:46], 2'b01, "start and transmitter bits");
        check_value(frame[45:40], idx, "command index");
        check_value(frame[39:8], arg, "command argument");
        check_value(frame[7:1], compute_crc7(frame[47:8]), "command CRC7");
        check_value(frame[0], 1'b1, "end bit");
    endtask

    // One idle falling edge lets the controller turn the line around
    task automatic send_response(input logic [135:0] bits, input int nbits);
        @(negedge o_sclk);
        for (int i = nbits - 1; i >= 0; i--) begin
            @(negedge o_sclk);
            @(negedge i_clk);
            check_value(o_cmd_dir, 1'b1, "cmd_dir while the card drives");
            i_cmd = bits[i];
        end
    endtask

    task automatic run_card(input int kind, input int busy, input logic [15:0] rca);
        logic [47:0] frame;
        logic [31:0] cmd8_arg;
        logic [31:0] acmd41_arg;
        int          idle;
        logic        hcs_exp;
        hcs_exp = (kind != SCEN_V1);
        // VHS sits in bits 11:8 and the check pattern in bits 7:0
        cmd8_arg = (32'(i_vhs) << 8) | 32'(i_check_pattern);
        // HCS in bit 30 and the 0xFF8000 voltage window in bits 23:0
        acmd41_arg = hcs_exp ? 32'h40FF_8000 : 32'h00FF_8000;
        receive_frame(1'b1, frame, idle);
        check_value(idle >= SD_PREINIT_CLKS, 1'b1, "too few idle clocks before CMD0");
        check_frame(frame, 6'd0, 32'h0);
        send_response(build_short_resp(6'd0, CARD_STATUS, 1'b0), SD_CMD_BITS);
        receive_frame(1'b0, frame, idle);
        check_frame(frame, 6'd8, cmd8_arg);
        // A v1.x card ignores CMD8
        if (kind != SCEN_V1) begin
            send_response(build_short_resp(6'd8, cmd8_arg, 1'b0), SD_CMD_BITS);
        end
        for (int round = 0; round <= busy; round++) begin
            receive_frame(1'b0, frame, idle);
            check_frame(frame, 6'd55, 32'h0);
            send_response(build_short_resp(6'd55, CARD_STATUS, 1'b0), SD_CMD_BITS);
            receive_frame(1'b0, frame, idle);
            check_frame(frame, 6'd41, acmd41_arg);
            send_response(build_ocr_resp(round == busy, kind == SCEN_V2_HC), SD_CMD_BITS);
        end
        receive_frame(1'b0, frame, idle);
        check_frame(frame, 6'd2, 32'h0);
        send_response(build_cid_resp(), SD_R2_BITS);
        receive_frame(1'b0, frame, idle);
        check_frame(frame, 6'd3, 32'h0);
        send_response(build_short_resp(6'd3, {rca, 16'h0500}, kind == SCEN_BAD_CRC),
            SD_CMD_BITS);
    endtask

    task automatic measure_sclk();
        logic prev;
        int   cycles;
        @(negedge i_clk);
        prev = o_sclk;
        while (o_sclk == prev) begin
            @(negedge i_clk);
        end
        for (int n = 0; n < 4; n++) begin
            prev = o_sclk;
            cycles = 0;
            while (o_sclk == prev) begin
                @(negedge i_clk);
                cycles++;
            end
            check_value(cycles, CLK_DIV + 1, "sclk half period in clk cycles");
        end
    endtask

    task automatic run_scenario(input int kind);
        int          busy;
        logic [15:0] rca;
        busy = 1 + ($urandom % MAX_BUSY);
        rca = 16'($urandom) | 16'h0001;
        @(negedge i_clk);
        i_nrst = 1'b0;
        info_checked = 1'b0;
        i_cmd = 1'b1;
        i_vhs = 4'h1;
        i_check_pattern = 8'($urandom);
        exp_info = expected_info(kind, rca);
        repeat (RESET_CYCLES) @(negedge i_clk);
        check_value(o_cmd, 1'b1, "cmd in reset");
        check_value(o_cmd_dir, 1'b0, "cmd_dir in reset");
        check_value(o_sclk, 1'b0, "sclk in reset");
        i_nrst = 1'b1;
        fork
            run_card(kind, busy, rca);
            measure_sclk();
        join
        while (!info_checked) begin
            @(negedge i_clk);
        end
        repeat (20) begin
            @(negedge i_clk);
            check_value(o_init_done, 1'b1, "init_done dropped");
        end
    endtask

    // Compares the card info at the first cycle of init_done in each scenario
    always @(negedge i_clk) begin
        if (i_nrst && o_init_done && !info_checked) begin
            check_value(o_card_info, exp_info, "card info at init done");
            info_checked = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the scenarios completed");
        $display("Some tests failed");
        $fatal(1, "simulation timed out");
    end

    initial begin
        void'($urandom(32'h30fd));
        i_nrst = 1'b0;
        i_clk_div = SD_CLKDIV_W'(CLK_DIV);
        i_vhs = 4'h1;
        i_check_pattern = 8'hAA;
        i_cmd = 1'b1;
        info_checked = 1'b1;
        exp_info = '0;
        // CMD0 frame is 40 00 00 00 00 95
        check_value(compute_crc7(40'h40_0000_0000), 7'h4A, "CRC7 reference for CMD0");
        for (scen = 0; scen < N_SCEN; scen++) begin
            run_scenario(scen);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sd_init_top.sv ====
// Top level of the SD identification controller, connecting divider, CMD line and FSM
`default_nettype none
`timescale 1ns/10ps

module sd_init_top
    import sd_init_pkg::*;
(
    input  wire logic                   i_clk,
    input  wire logic                   i_nrst,
    input  wire logic [SD_CLKDIV_W-1:0] i_clk_div,
    input  wire logic             [3:0] i_vhs,
    input  wire logic             [7:0] i_check_pattern,
    input  wire logic                   i_cmd,
    output logic                        o_sclk,
    output logic                        o_cmd,
    output logic                        o_cmd_dir,
    output sd_card_info_t               o_card_info,
    output logic                        o_init_done
);

    logic         sclk_rise;
    logic         sclk_fall;
    logic         req_valid;
    sd_cmd_req_t  req;
    logic         resp_done;
    sd_cmd_resp_t resp;

    sd_clk_div u_clk_div (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_clk_div   (i_clk_div),
        .o_sclk      (o_sclk),
        .o_sclk_rise (sclk_rise),
        .o_sclk_fall (sclk_fall)
    );

    sd_cmd_line u_cmd_line (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_sclk_rise (sclk_rise),
        .i_sclk_fall (sclk_fall),
        .i_req_valid (req_valid),
        .i_req       (req),
        .o_resp_done (resp_done),
        .o_resp      (resp),
        .i_cmd       (i_cmd),
        .o_cmd       (o_cmd),
        .o_cmd_dir   (o_cmd_dir)
    );

    sd_init_fsm u_init_fsm (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_sclk_rise     (sclk_rise),
        .i_vhs           (i_vhs),
        .i_check_pattern (i_check_pattern),
        .o_req_valid     (req_valid),
        .o_req           (req),
        .i_resp_done     (resp_done),
        .i_resp          (resp),
        .o_card_info     (o_card_info),
        .o_init_done     (o_init_done)
    );

endmodule

`default_nettype wire

// ==== sd_init_fsm.sv ====
// Card identification sequence from pre-init through CMD3 with card state tracking
`default_nettype none
`timescale 1ns/10ps

module sd_init_fsm
    import sd_init_pkg::*;
(
    input  wire logic          i_clk,
    input  wire logic          i_nrst,
    input  wire logic          i_sclk_rise,
    input  wire logic    [3:0] i_vhs,
    input  wire logic    [7:0] i_check_pattern,
    output logic               o_req_valid,
    output sd_cmd_req_t        o_req,
    input  wire logic          i_resp_done,
    input  wire sd_cmd_resp_t  i_resp,
    output sd_card_info_t      o_card_info,
    output logic               o_init_done
);

    typedef enum logic [2:0] {
        STEP_PREINIT,
        STEP_CMD0,
        STEP_CMD8,
        STEP_CMD55,
        STEP_ACMD41,
        STEP_CMD2,
        STEP_CMD3,
        STEP_DONE
    } step_e;

    step_e       step;
    logic        wait_resp;
    logic        hcs;
    logic [6:0]  clkcnt;
    sd_cmd_req_t next_req;

    // Command, argument and expected response for the current step
    always_comb begin
        next_req = '{cmd: CMD0, arg: '0, kind: RESP_R1};
        case (step)
            STEP_CMD8: begin
                next_req = '{cmd: CMD8, arg: {20'h0, i_vhs, i_check_pattern}, kind: RESP_R7};
            end
            STEP_CMD55: begin
                next_req = '{cmd: CMD55, arg: '0, kind: RESP_R1};
            end
            STEP_ACMD41: begin
                next_req = '{cmd: ACMD41, arg: {1'b0, hcs, 6'h0, SD_OCR_DEFAULT},
                    kind: RESP_R3};
            end
            STEP_CMD2: begin
                next_req = '{cmd: CMD2, arg: '0, kind: RESP_R2};
            end
            STEP_CMD3: begin
                next_req = '{cmd: CMD3, arg: '0, kind: RESP_R6};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            step <= STEP_PREINIT;
            wait_resp <= 1'b0;
            hcs <= 1'b1;
            clkcnt <= '0;
            o_req_valid <= 1'b0;
            o_req <= '0;
            o_card_info <= '{state: SDSTATE_PRE_INIT, sdtype: SDCARD_UNKNOWN, rca: '0};
        end else begin
            o_req_valid <= 1'b0;
            if (wait_resp) begin
                if (i_resp_done) begin
                    wait_resp <= 1'b0;
                    if (o_req.cmd == CMD8 && i_resp.err == CMDERR_NO_RESP) begin
                        // Silent on CMD8 means a version 1.x card
                        o_card_info.sdtype <= SDCARD_VER1X;
                        hcs <= 1'b0;
                        step <= STEP_CMD55;
                    end else if (i_resp.err != CMDERR_NONE) begin
                        if (o_req.cmd == CMD0) begin
                            step <= STEP_CMD0;
                        end else begin
                            o_card_info.state <= SDSTATE_INA;
                            o_card_info.sdtype <= SDCARD_UNUSABLE;
                            step <= STEP_DONE;
                        end
                    end else begin
                        case (o_req.cmd)
                            CMD0: step <= STEP_CMD8;
                            CMD8: step <= STEP_CMD55;
                            CMD55: step <= STEP_ACMD41;
                            ACMD41: begin
                                // OCR bit 31 low while the card is still powering up
                                if (i_resp.data[31]) begin
                                    hcs <= i_resp.data[30];
                                    if (i_resp.data[30]) begin
                                        o_card_info.sdtype <= SDCARD_VER2X_HC;
                                    end else if (o_card_info.sdtype == SDCARD_UNKNOWN) begin
                                        o_card_info.sdtype <= SDCARD_VER2X_SC;
                                    end
                                    o_card_info.state <= SDSTATE_READY;
                                    step <= STEP_CMD2;
                                end else begin
                                    step <= STEP_CMD55;
                                end
                            end
                            CMD2: begin
                                o_card_info.state <= SDSTATE_IDENT;
                                step <= STEP_CMD3;
                            end
                            default: begin
                                o_card_info.rca <= i_resp.data[31:16];
                                o_card_info.state <= SDSTATE_STBY;
                                step <= STEP_DONE;
                            end
                        endcase
                    end
                end
            end else begin
                case (step)
                    STEP_PREINIT: begin
                        if (i_sclk_rise) begin
                            if (clkcnt == 7'(SD_PREINIT_CLKS - 1)) begin
                                o_card_info.state <= SDSTATE_IDLE;
                                step <= STEP_CMD0;
                            end else begin
                                clkcnt <= clkcnt + 7'd1;
                            end
                        end
                    end
                    STEP_DONE: begin
                    end
                    default: begin
                        o_req <= next_req;
                        o_req_valid <= 1'b1;
                        wait_resp <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Stand-by and inactive are terminal for this sequence
    assign o_init_done = (o_card_info.state == SDSTATE_STBY)
        || (o_card_info.state == SDSTATE_INA);

endmodule

`default_nettype wire

// ==== sd_cmd_line.sv ====
// CMD line engine that sends 48-bit command frames and receives checked responses
`default_nettype none
`timescale 1ns/10ps

module sd_cmd_line
    import sd_init_pkg::*;
(
    input  wire logic         i_clk,
    input  wire logic         i_nrst,
    input  wire logic         i_sclk_rise,
    input  wire logic         i_sclk_fall,
    input  wire logic         i_req_valid,
    input  wire sd_cmd_req_t  i_req,
    output logic              o_resp_done,
    output sd_cmd_resp_t      o_resp,
    input  wire logic         i_cmd,
    output logic              o_cmd,
    output logic              o_cmd_dir
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_TX,
        ST_RX_WAIT,
        ST_RX,
        ST_CHECK
    } line_state_e;

    line_state_e   state;
    logic [7:0]    cnt;
    logic [6:0]    tout;
    logic [5:0]    cmd_idx;
    sd_resp_kind_e kind;
    logic [39:0]   tx_sr;
    logic [45:0]   rx_sr;
    logic [6:0]    crc_tx;
    logic [6:0]    crc_rx;
    logic [7:0]    last_bit;
    logic          req_accept;
    logic          tx_hdr_bit;
    logic          rx_start;
    logic          rx_crc_bit;
    logic          timeout_hit;
    sd_cmd_err_e   chk_err;

    assign req_accept = (state == ST_IDLE) && i_req_valid;
    assign tx_hdr_bit = (state == ST_TX) && i_sclk_fall && (cnt < 8'(SD_HDR_BITS));
    assign rx_start = (state == ST_RX_WAIT) && i_sclk_rise && !i_cmd;
    assign rx_crc_bit = rx_start
        || ((state == ST_RX) && i_sclk_rise && (cnt < 8'(SD_HDR_BITS)));
    assign timeout_hit = (state == ST_RX_WAIT) && i_sclk_rise && i_cmd
        && (tout == 7'(SD_RESP_TIMEOUT - 1));
    assign last_bit = (kind == RESP_R2) ? 8'(SD_R2_BITS - 1) : 8'(SD_CMD_BITS - 1);

    sd_crc7 u_crc_tx (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (req_accept),
        .i_next  (tx_hdr_bit),
        .i_bit   (tx_sr[39]),
        .o_crc7  (crc_tx)
    );

    sd_crc7 u_crc_rx (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (req_accept),
        .i_next  (rx_crc_bit),
        .i_bit   (i_cmd),
        .o_crc7  (crc_rx)
    );

    // R3 carries all ones in place of index and CRC, R2 is only counted
    always_comb begin
        chk_err = CMDERR_NONE;
        if (kind == RESP_R1 || kind == RESP_R6 || kind == RESP_R7) begin
            if (rx_sr[7:1] != crc_rx) begin
                chk_err = CMDERR_CRC;
            end else if (rx_sr[45:40] != cmd_idx) begin
                chk_err = CMDERR_INDEX;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= ST_IDLE;
            cnt <= '0;
            tout <= '0;
            cmd_idx <= '0;
            kind <= RESP_R1;
            o_cmd <= 1'b1;
            o_cmd_dir <= 1'b0;
            o_resp_done <= 1'b0;
        end else begin
            o_resp_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_req_valid) begin
                        cmd_idx <= i_req.cmd;
                        kind <= i_req.kind;
                        cnt <= '0;
                        state <= ST_TX;
                    end
                end
                ST_TX: begin
                    if (i_sclk_fall) begin
                        cnt <= cnt + 8'd1;
                        if (cnt < 8'(SD_HDR_BITS)) begin
                            o_cmd <= tx_sr[39];
                        end else if (cnt < 8'(SD_CMD_BITS - 1)) begin
                            o_cmd <= crc_tx[3'(8'(SD_CMD_BITS - 2) - cnt)];
                        end else if (cnt == 8'(SD_CMD_BITS - 1)) begin
                            // End bit
                            o_cmd <= 1'b1;
                        end else begin
                            // End bit has had its full clock, release the line
                            o_cmd_dir <= 1'b1;
                            tout <= '0;
                            state <= ST_RX_WAIT;
                        end
                    end
                end
                ST_RX_WAIT: begin
                    if (rx_start) begin
                        cnt <= 8'd1;
                        state <= ST_RX;
                    end else if (timeout_hit) begin
                        o_cmd_dir <= 1'b0;
                        o_resp_done <= 1'b1;
                        state <= ST_IDLE;
                    end else if (i_sclk_rise) begin
                        tout <= tout + 7'd1;
                    end
                end
                ST_RX: begin
                    if (i_sclk_rise) begin
                        if (cnt == last_bit) begin
                            state <= ST_CHECK;
                        end else begin
                            cnt <= cnt + 8'd1;
                        end
                    end
                end
                default: begin
                    o_cmd_dir <= 1'b0;
                    o_resp_done <= 1'b1;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Frame and response payload
    always_ff @(posedge i_clk) begin
        if (req_accept) begin
            tx_sr <= {2'b01, i_req.cmd, i_req.arg};
        end else if (tx_hdr_bit) begin
            tx_sr <= {tx_sr[38:0], 1'b0};
        end
        if ((state == ST_RX) && i_sclk_rise) begin
            rx_sr <= {rx_sr[44:0], i_cmd};
        end
        if (timeout_hit) begin
            o_resp <= '{cmd: cmd_idx, data: '0, err: CMDERR_NO_RESP};
        end else if (state == ST_CHECK) begin
            o_resp <= '{cmd: rx_sr[45:40], data: rx_sr[39:8], err: chk_err};
        end
    end

    // The FSM waits for resp_done, so a request never lands on a busy line
    a_req_when_idle: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_req_valid |-> (state == ST_IDLE)
    );

endmodule

`default_nettype wire

// ==== sd_clk_div.sv ====
// SD clock divider producing the card clock and one-cycle strobes on its edges
`default_nettype none
`timescale 1ns/10ps

module sd_clk_div
    import sd_init_pkg::*;
(
    input  wire logic                   i_clk,
    input  wire logic                   i_nrst,
    input  wire logic [SD_CLKDIV_W-1:0] i_clk_div,
    output logic                        o_sclk,
    output logic                        o_sclk_rise,
    output logic                        o_sclk_fall
);

    logic [SD_CLKDIV_W-1:0] cnt;

    // Half period is i_clk_div + 1 cycles
    // The divisor reloads on each toggle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt <= '0;
            o_sclk <= 1'b0;
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
        end else begin
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
            if (cnt == '0) begin
                cnt <= i_clk_div;
                o_sclk <= ~o_sclk;
                // Strobe marks the edge that o_sclk makes in this same cycle
                o_sclk_rise <= ~o_sclk;
                o_sclk_fall <= o_sclk;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Command line logic relies on exactly one edge action per cycle
    // Rise needs a high o_sclk and fall a low one, so they never coincide
    a_rise_marks_edge: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_sclk_rise |-> (o_sclk && !$past(o_sclk))
    );

    a_fall_marks_edge: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_sclk_fall |-> (!o_sclk && $past(o_sclk))
    );

endmodule

`default_nettype wire

// ==== sd_crc7.sv ====
// Bit-serial CRC7 over the command line, cleared per frame and stepped once per bit
`default_nettype none
`timescale 1ns/10ps

module sd_crc7
    import sd_init_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_nrst,
    input  wire logic       i_clear,
    input  wire logic       i_next,
    input  wire logic       i_bit,
    output logic      [6:0] o_crc7
);

    logic feedback;

    assign feedback = i_bit ^ o_crc7[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc7 <= '0;
        end else if (i_clear) begin
            o_crc7 <= '0;
        end else if (i_next) begin
            o_crc7 <= {o_crc7[5:0], 1'b0} ^ ({7{feedback}} & SD_CRC7_POLY);
        end
    end

endmodule

`default_nettype wire

// ==== sd_init_pkg.sv ====
// Shared constants, encodings and packed structs for the SD card identification controller
`default_nettype none

package sd_init_pkg;

    // Frame and timing constants
    localparam int SD_PREINIT_CLKS = 74;
    localparam int SD_RESP_TIMEOUT = 64;
    localparam int SD_CMD_BITS = 48;
    localparam int SD_R2_BITS = 136;
    // Start, transmitter, index and argument bits covered by CRC7
    localparam int SD_HDR_BITS = SD_CMD_BITS - 8;
    localparam int SD_CLKDIV_W = 8;
    localparam logic [23:0] SD_OCR_DEFAULT = 24'hFF8000;
    // x^7 + x^3 + 1
    localparam logic [6:0] SD_CRC7_POLY = 7'h09;

    typedef enum logic [5:0] {
        CMD0   = 6'd0,
        CMD2   = 6'd2,
        CMD3   = 6'd3,
        CMD8   = 6'd8,
        ACMD41 = 6'd41,
        CMD55  = 6'd55
    } sd_cmd_e;

    typedef enum logic [2:0] {
        RESP_R1,
        RESP_R2,
        RESP_R3,
        RESP_R6,
        RESP_R7
    } sd_resp_kind_e;

    typedef enum logic [1:0] {
        CMDERR_NONE,
        CMDERR_NO_RESP,
        CMDERR_CRC,
        CMDERR_INDEX
    } sd_cmd_err_e;

    typedef enum logic [2:0] {
        SDSTATE_PRE_INIT,
        SDSTATE_IDLE,
        SDSTATE_READY,
        SDSTATE_IDENT,
        SDSTATE_STBY,
        SDSTATE_INA
    } sd_state_e;

    typedef enum logic [2:0] {
        SDCARD_UNKNOWN,
        SDCARD_VER1X,
        SDCARD_VER2X_SC,
        SDCARD_VER2X_HC,
        SDCARD_UNUSABLE
    } sd_type_e;

    typedef struct packed {
        sd_cmd_e       cmd;
        logic [31:0]   arg;
        sd_resp_kind_e kind;
    } sd_cmd_req_t;

    typedef struct packed {
        logic [5:0]  cmd;
        logic [31:0] data;
        sd_cmd_err_e err;
    } sd_cmd_resp_t;

    typedef struct packed {
        sd_state_e   state;
        sd_type_e    sdtype;
        logic [15:0] rca;
    } sd_card_info_t;

endpackage

`default_nettype wire
